//--- src/pkt_switch_pkg.sv
`default_nettype none

package pkt_switch_pkg;

    localparam int PORTS      = 4;
    localparam int PORT_W     = 2;
    localparam int DATA_W     = 16;
    localparam int PRIO_W     = 2;
    localparam int LEN_W      = 6;
    localparam int RSVD_W     = DATA_W - PORT_W - PRIO_W - LEN_W;
    localparam int LEN_MAX    = 30;     // payload words, header not counted
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;

    typedef struct packed {
        logic [PORT_W-1:0] dest;        // source number on the way out
        logic [PRIO_W-1:0] prio;
        logic [RSVD_W-1:0] rsvd;
        logic [LEN_W-1:0]  len;
    } pkt_header_t;

    // first word of a packet is read as hdr, the rest as raw
    typedef union packed {
        pkt_header_t       hdr;
        logic [DATA_W-1:0] raw;
    } pkt_word_u;

    typedef struct packed {
        logic      eop;
        pkt_word_u word;
    } fifo_word_t;

endpackage

`default_nettype wire

//--- src/packet_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module packet_fifo (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               wr_en,
    input  wire pkt_switch_pkg::fifo_word_t   wr_word,
    input  wire                               commit,
    input  wire                               discard,
    input  wire                               rd_en,
    output pkt_switch_pkg::fifo_word_t        head_word,
    output logic                              pkt_avail,
    output logic [pkt_switch_pkg::FIFO_AW:0]  free_words
);

    pkt_switch_pkg::fifo_word_t mem [pkt_switch_pkg::FIFO_DEPTH];

    logic [pkt_switch_pkg::FIFO_AW:0] wr_ptr;      // working, includes open packet
    logic [pkt_switch_pkg::FIFO_AW:0] cmt_ptr;     // end of last committed packet
    logic [pkt_switch_pkg::FIFO_AW:0] rd_ptr;
    logic [pkt_switch_pkg::FIFO_AW:0] base_ptr;
    logic [pkt_switch_pkg::FIFO_AW:0] wr_ptr_nxt;
    logic [pkt_switch_pkg::FIFO_AW:0] pkt_cnt;
    logic                             pop_pkt;

    assign base_ptr   = discard ? cmt_ptr : wr_ptr;    // rewind to packet start
    assign wr_ptr_nxt = base_ptr + wr_en;
    assign pop_pkt    = rd_en & head_word.eop;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[base_ptr[pkt_switch_pkg::FIFO_AW-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            rd_ptr <= rd_ptr + rd_en;
            if (commit) begin
                cmt_ptr <= wr_ptr_nxt;  // publish eop word too
            end
            case ({commit, pop_pkt})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: ;
            endcase
        end
    end

    assign head_word  = mem[rd_ptr[pkt_switch_pkg::FIFO_AW-1:0]];   // show-ahead
    assign pkt_avail  = (pkt_cnt != '0);
    assign free_words = (pkt_switch_pkg::FIFO_AW+1)'(pkt_switch_pkg::FIFO_DEPTH)
                        - (wr_ptr - rd_ptr);

endmodule

`default_nettype wire

//--- src/ingress_port.sv
`timescale 1ns/1ns
`default_nettype none

module ingress_port (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               wr_sop,
    input  wire                               wr_eop,
    input  wire                               wr_vld,
    input  wire [pkt_switch_pkg::DATA_W-1:0]  wr_data,
    input  wire                               rd_en,
    output pkt_switch_pkg::fifo_word_t        head_word,
    output logic                              pkt_avail,
    output logic [pkt_switch_pkg::FIFO_AW:0]  free_words,
    output logic                              drop
);

    pkt_switch_pkg::pkt_word_u  in_word;
    pkt_switch_pkg::fifo_word_t wr_word;

    logic                             in_pkt;
    logic                             in_pkt_nxt;
    logic [pkt_switch_pkg::LEN_W-1:0] len_q;
    logic [pkt_switch_pkg::LEN_W-1:0] cnt_q;
    logic [pkt_switch_pkg::LEN_W-1:0] cnt_nxt;
    logic                             wr_en;
    logic                             commit;
    logic                             discard;
    logic                             drop_nxt;
    logic                             ovf;
    logic                             len_bad;

    assign in_word = wr_data;
    assign wr_word = '{eop: wr_eop, word: in_word};
    assign cnt_nxt = cnt_q + 1'b1;
    assign ovf     = (free_words == '0);    // no room for this word
    assign len_bad = (in_word.hdr.len > pkt_switch_pkg::LEN_MAX)
                     || (wr_eop && in_word.hdr.len != '0);

    always_comb begin
        wr_en      = 1'b0;
        commit     = 1'b0;
        discard    = 1'b0;
        drop_nxt   = 1'b0;
        in_pkt_nxt = in_pkt;
        if (wr_vld && wr_sop) begin
            discard  = in_pkt;              // open packet lost its eop
            drop_nxt = in_pkt;
            if (ovf || len_bad) begin
                drop_nxt   = 1'b1;
                in_pkt_nxt = 1'b0;
            end else begin
                wr_en      = 1'b1;
                commit     = wr_eop;        // header-only packet
                in_pkt_nxt = !wr_eop;
            end
        end else if (wr_vld && in_pkt) begin
            // too short at eop, or one word past len
            if (ovf || (wr_eop ? cnt_nxt != len_q : cnt_q == len_q)) begin
                discard    = 1'b1;
                drop_nxt   = 1'b1;
                in_pkt_nxt = 1'b0;
            end else begin
                wr_en      = 1'b1;
                commit     = wr_eop;
                in_pkt_nxt = !wr_eop;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt <= 1'b0;
            drop   <= 1'b0;
            len_q  <= '0;
            cnt_q  <= '0;
        end else begin
            in_pkt <= in_pkt_nxt;
            drop   <= drop_nxt;
            if (wr_vld && wr_sop) begin
                len_q <= in_word.hdr.len;
                cnt_q <= '0;
            end else if (wr_en) begin
                cnt_q <= cnt_nxt;
            end
        end
    end

    packet_fifo u_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_word    (wr_word),
        .commit     (commit),
        .discard    (discard),
        .rd_en      (rd_en),
        .head_word  (head_word),
        .pkt_avail  (pkt_avail),
        .free_words (free_words)
    );

endmodule

`default_nettype wire

//--- src/egress_port.sv
`timescale 1ns/1ns
`default_nettype none

module egress_port #(
    parameter int OUT_PORT = 0
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire pkt_switch_pkg::fifo_word_t  head_word [pkt_switch_pkg::PORTS],
    input  wire [pkt_switch_pkg::PORTS-1:0]  pkt_avail,
    output logic [pkt_switch_pkg::PORTS-1:0] rd_en,
    output logic                             rd_sop,
    output logic                             rd_eop,
    output logic                             rd_vld,
    output logic [pkt_switch_pkg::DATA_W-1:0] rd_data
);

    logic [pkt_switch_pkg::PORTS-1:0]  cand;
    logic [pkt_switch_pkg::PRIO_W-1:0] best_prio;
    logic [pkt_switch_pkg::PORT_W-1:0] win;
    logic [pkt_switch_pkg::PORT_W-1:0] idx;
    logic [pkt_switch_pkg::PORT_W-1:0] src;
    logic [pkt_switch_pkg::PORT_W-1:0] rr_ptr;
    logic                              found;
    logic                              busy;
    logic                              first;

    pkt_switch_pkg::fifo_word_t cur_word;
    pkt_switch_pkg::pkt_word_u  out_word;

    // heads waiting for this output
    always_comb begin
        for (int i = 0; i < pkt_switch_pkg::PORTS; i++) begin
            cand[i] = pkt_avail[i] && (head_word[i].word.hdr.dest == OUT_PORT);
        end
    end

    always_comb begin
        best_prio = '0;
        for (int i = 0; i < pkt_switch_pkg::PORTS; i++) begin
            if (cand[i] && head_word[i].word.hdr.prio > best_prio) begin
                best_prio = head_word[i].word.hdr.prio;
            end
        end
    end

    // first top-prio candidate at or after rr_ptr
    always_comb begin
        found = 1'b0;
        win   = rr_ptr;
        idx   = rr_ptr;
        for (int k = 0; k < pkt_switch_pkg::PORTS; k++) begin
            idx = rr_ptr + k[pkt_switch_pkg::PORT_W-1:0];
            if (!found && cand[idx] && head_word[idx].word.hdr.prio == best_prio) begin
                win   = idx;
                found = 1'b1;
            end
        end
    end

    assign cur_word = head_word[src];

    always_comb begin
        rd_en      = '0;
        rd_en[src] = busy;              // one word per cycle while granted
    end

    always_comb begin
        out_word = cur_word.word;
        if (first) begin
            out_word.hdr.dest = src;    // tell the sink where it came from
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            first  <= 1'b0;
            src    <= '0;
            rr_ptr <= '0;
        end else if (!busy) begin
            if (found) begin
                busy   <= 1'b1;
                first  <= 1'b1;
                src    <= win;
                rr_ptr <= win + 1'b1;
            end
        end else begin
            first <= 1'b0;
            if (cur_word.eop) begin
                busy <= 1'b0;           // release on eop read
            end
        end
    end

    // output stage, one cycle behind the read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld  <= 1'b0;
            rd_sop  <= 1'b0;
            rd_eop  <= 1'b0;
            rd_data <= '0;
        end else begin
            rd_vld  <= busy;
            rd_sop  <= busy & first;
            rd_eop  <= busy & cur_word.eop;
            rd_data <= busy ? out_word.raw : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/pkt_switch.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_switch (
    input  wire                                                    clk,
    input  wire                                                    arst_n,
    input  wire [pkt_switch_pkg::PORTS-1:0]                        wr_sop,
    input  wire [pkt_switch_pkg::PORTS-1:0]                        wr_eop,
    input  wire [pkt_switch_pkg::PORTS-1:0]                        wr_vld,
    input  wire [pkt_switch_pkg::PORTS*pkt_switch_pkg::DATA_W-1:0] wr_data,
    output wire [pkt_switch_pkg::PORTS-1:0]                        rd_sop,
    output wire [pkt_switch_pkg::PORTS-1:0]                        rd_eop,
    output wire [pkt_switch_pkg::PORTS-1:0]                        rd_vld,
    output wire [pkt_switch_pkg::PORTS*pkt_switch_pkg::DATA_W-1:0] rd_data,
    output logic                                                   full,
    output wire [pkt_switch_pkg::PORTS-1:0]                        drop
);

    pkt_switch_pkg::fifo_word_t       head_word  [pkt_switch_pkg::PORTS];
    logic [pkt_switch_pkg::FIFO_AW:0] free_words [pkt_switch_pkg::PORTS];
    logic [pkt_switch_pkg::PORTS-1:0] rd_req     [pkt_switch_pkg::PORTS];  // per egress
    logic [pkt_switch_pkg::PORTS-1:0] fifo_rd_en;
    wire  [pkt_switch_pkg::PORTS-1:0] pkt_avail;
    wire  [pkt_switch_pkg::PORTS-1:0] head_free;
    wire  [pkt_switch_pkg::PORTS-1:0] low_space;

    for (genvar i = 0; i < pkt_switch_pkg::PORTS; i++) begin : g_in
        ingress_port u_in (
            .clk        (clk),
            .arst_n     (arst_n),
            .wr_sop     (wr_sop[i]),
            .wr_eop     (wr_eop[i]),
            .wr_vld     (wr_vld[i]),
            .wr_data    (wr_data[i*pkt_switch_pkg::DATA_W +: pkt_switch_pkg::DATA_W]),
            .rd_en      (fifo_rd_en[i]),
            .head_word  (head_word[i]),
            .pkt_avail  (pkt_avail[i]),
            .free_words (free_words[i]),
            .drop       (drop[i])
        );
        assign low_space[i] = (free_words[i] < pkt_switch_pkg::LEN_MAX + 1);
    end

    for (genvar j = 0; j < pkt_switch_pkg::PORTS; j++) begin : g_out
        egress_port #(
            .OUT_PORT (j)
        ) u_out (
            .clk       (clk),
            .arst_n    (arst_n),
            .head_word (head_word),
            .pkt_avail (head_free),
            .rd_en     (rd_req[j]),
            .rd_sop    (rd_sop[j]),
            .rd_eop    (rd_eop[j]),
            .rd_vld    (rd_vld[j]),
            .rd_data   (rd_data[j*pkt_switch_pkg::DATA_W +: pkt_switch_pkg::DATA_W])
        );
    end

    // at most one egress holds a given input
    always_comb begin
        fifo_rd_en = '0;
        for (int j = 0; j < pkt_switch_pkg::PORTS; j++) begin
            fifo_rd_en = fifo_rd_en | rd_req[j];
        end
    end

    assign head_free = pkt_avail & ~fifo_rd_en;    // head is a header only between reads

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else begin
            full <= |low_space;     // less than one max packet left somewhere
        end
    end

endmodule

`default_nettype wire

//--- verification/pkt_switch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_switch_tb;

    localparam int NP    = pkt_switch_pkg::PORTS;
    localparam int DW    = pkt_switch_pkg::DATA_W;
    localparam int NROWS = 12;
    localparam int SLOTS = 256;     // expected words per dest/source stream

    logic            clk;
    logic            arst_n;
    logic [NP-1:0]   wr_sop;
    logic [NP-1:0]   wr_eop;
    logic [NP-1:0]   wr_vld;
    logic [NP*DW-1:0] wr_data;
    wire  [NP-1:0]   rd_sop;
    wire  [NP-1:0]   rd_eop;
    wire  [NP-1:0]   rd_vld;
    wire  [NP*DW-1:0] rd_data;
    wire             full;
    wire  [NP-1:0]   drop;

    // stimulus table packed two or six bits per port from port 0 up
    logic [NP-1:0]   t_start [NROWS];
    logic [2*NP-1:0] t_dest  [NROWS];
    logic [2*NP-1:0] t_prio  [NROWS];
    logic [6*NP-1:0] t_len   [NROWS];
    logic [2*NP-1:0] t_err   [NROWS];  // 0 good, 1 eop early, 2 eop late
    logic [7:0]      t_ord   [NROWS];  // arrival order of sources with the first in [1:0]
    int              t_ord_n [NROWS];
    int              t_wait  [NROWS];
    int              n_rows = 0;

    pkt_switch_pkg::fifo_word_t exp_word [NP*NP][SLOTS];
    int                         exp_row  [NP*NP][SLOTS];
    int                         wr_ix    [NP*NP];
    int                         rd_ix    [NP*NP];
    int                         arr_cnt  [NROWS];

    logic [pkt_switch_pkg::PORT_W-1:0] cur_src [NP];
    logic [NP-1:0] in_pkt;
    logic [NP-1:0] drop_pend;
    logic [NP-1:0] drop_due;
    logic          full_seen;
    logic [31:0]   rng;
    int            value_errs = 0;
    int            proto_errs = 0;
    int            cycles = 0;
    int            limit;

    pkt_switch uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .full    (full),
        .drop    (drop)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, traffic did not drain", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // header plus len payload words and one less or more for a bad eop
    function automatic int words_of(input int r, input int p);
        if (!t_start[r][p]) return 0;
        return t_len[r][6*p +: 6] + 1 + (t_err[r][2*p +: 2] == 2) - (t_err[r][2*p +: 2] == 1);
    endfunction

    function automatic bit drained();
        for (int s = 0; s < NP*NP; s++) begin
            if (rd_ix[s] != wr_ix[s]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_word(input string name, input pkt_switch_pkg::pkt_word_u got,
                              input pkt_switch_pkg::pkt_word_u exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_src(input string name, input logic [pkt_switch_pkg::PORT_W-1:0] got,
                             input logic [pkt_switch_pkg::PORT_W-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic [3:0] start, input logic [7:0] dest,
                           input logic [7:0] prio, input logic [23:0] len,
                           input logic [7:0] err, input int ord_n,
                           input logic [7:0] ord, input int wt);
        t_start[n_rows] = start;
        t_dest[n_rows]  = dest;
        t_prio[n_rows]  = prio;
        t_len[n_rows]   = len;
        t_err[n_rows]   = err;
        t_ord_n[n_rows] = ord_n;
        t_ord[n_rows]   = ord;
        t_wait[n_rows]  = wt;
        n_rows++;
    endtask

    task automatic check_idle();
        for (int p = 0; p < NP; p++) begin
            check_bit($sformatf("rd_sop[%0d]", p), rd_sop[p], 1'b0);
            check_bit($sformatf("rd_eop[%0d]", p), rd_eop[p], 1'b0);
            check_bit($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
            check_word($sformatf("rd_data[%0d]", p), rd_data[p*DW +: DW], '0);
            check_bit($sformatf("drop[%0d]", p), drop[p], 1'b0);
        end
        check_bit("full", full, 1'b0);
    endtask

    // entered and left at 5 ns after a rising edge
    task automatic send_row(input int r);
        pkt_switch_pkg::pkt_word_u  w;
        pkt_switch_pkg::fifo_word_t e;
        int nw [NP];
        int maxw;
        int s;
        maxw = 0;
        for (int p = 0; p < NP; p++) begin
            nw[p] = words_of(r, p);
            if (nw[p] > maxw) maxw = nw[p];
        end
        while (full) begin      // sources hold new packets while full
            @(posedge clk);
            #5;
        end
        for (int k = 0; k < maxw; k++) begin
            for (int p = 0; p < NP; p++) begin
                wr_vld[p] = 1'b0;
                wr_sop[p] = 1'b0;
                wr_eop[p] = 1'b0;
                if (k < nw[p]) begin
                    if (k == 0) begin
                        w.hdr.dest = t_dest[r][2*p +: 2];
                        w.hdr.prio = t_prio[r][2*p +: 2];
                        w.hdr.rsvd = rng[pkt_switch_pkg::RSVD_W-1:0];
                        w.hdr.len  = t_len[r][6*p +: 6];
                    end else begin
                        w.raw = rng[DW-1:0];
                    end
                    rng = xorshift(rng);
                    wr_vld[p] = 1'b1;
                    wr_sop[p] = (k == 0);
                    wr_eop[p] = (k == nw[p] - 1);
                    wr_data[p*DW +: DW] = w.raw;
                    if (t_err[r][2*p +: 2] == 0) begin
                        s = t_dest[r][2*p +: 2] * NP + p;
                        e.eop  = (k == nw[p] - 1);
                        e.word = w;
                        if (k == 0) e.word.hdr.dest = pkt_switch_pkg::PORT_W'(p);
                        exp_word[s][wr_ix[s]] = e;
                        exp_row[s][wr_ix[s]]  = r;
                        wr_ix[s]++;
                    end else if (k == nw[p] - 1) begin
                        drop_pend[p] = 1'b1;    // drop pulse follows the last word
                    end
                end
            end
            @(posedge clk);
            #5;
        end
        wr_vld = '0;
        wr_sop = '0;
        wr_eop = '0;
        repeat (t_wait[r]) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic watch_output(input int j);
        pkt_switch_pkg::pkt_word_u  got;
        pkt_switch_pkg::fifo_word_t e;
        int s;
        int r;
        got.raw = rd_data[j*DW +: DW];
        if (!rd_vld[j]) begin
            check_bit($sformatf("rd_sop[%0d]", j), rd_sop[j], 1'b0);
            check_bit($sformatf("rd_eop[%0d]", j), rd_eop[j], 1'b0);
            return;
        end
        if (rd_sop[j]) begin
            if (in_pkt[j]) begin
                proto_errs++;
                $display("output %0d started a packet before the last one ended", j);
            end
            in_pkt[j]  = 1'b1;
            cur_src[j] = got.hdr.dest;   // rewritten to the source port
        end else if (!in_pkt[j]) begin
            proto_errs++;
            $display("output %0d sent a word outside any packet at %0t", j, $time);
            return;
        end
        s = j * NP + cur_src[j];
        if (rd_ix[s] == wr_ix[s]) begin
            proto_errs++;
            $display("output %0d sent a word from source %0d that was never sent", j, cur_src[j]);
        end else begin
            e = exp_word[s][rd_ix[s]];
            r = exp_row[s][rd_ix[s]];
            if (rd_sop[j]) begin
                if (arr_cnt[r] < t_ord_n[r]) begin
                    check_src($sformatf("source order of row %0d", r), cur_src[j],
                              t_ord[r][2*arr_cnt[r] +: 2]);
                end
                arr_cnt[r]++;
            end
            check_word($sformatf("rd_data[%0d]", j), got, e.word);
            check_bit($sformatf("rd_eop[%0d]", j), rd_eop[j], e.eop);
            rd_ix[s]++;
        end
        if (rd_eop[j]) in_pkt[j] = 1'b0;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int j = 0; j < NP; j++) begin
                watch_output(j);
                check_bit($sformatf("drop[%0d]", j), drop[j], drop_due[j]);
            end
            drop_due  = drop_pend;
            drop_pend = '0;
            if (full) full_seen = 1'b1;
        end
    end

    initial begin
        arst_n    = 1'b0;
        wr_sop    = '0;
        wr_eop    = '0;
        wr_vld    = '0;
        wr_data   = '0;
        in_pkt    = '0;
        drop_pend = '0;
        drop_due  = '0;
        full_seen = 1'b0;
        rng       = 32'he5af_26ad;
        for (int s = 0; s < NP*NP; s++) begin
            wr_ix[s] = 0;
            rd_ix[s] = 0;
        end
        for (int r = 0; r < NROWS; r++) arr_cnt[r] = 0;

        //      start    dest(3..0)   prio(3..0)   len(3..0)                  err
        add_row(4'b1111, 8'b00_11_10_01, 8'b00_01_10_11, {6'd30, 6'd0, 6'd6, 6'd4},
                8'b0, 0, 8'b0, 40);
        add_row(4'b1100, 8'b01_01_00_00, 8'b0, {6'd3, 6'd5, 6'd0, 6'd0},
                8'b10_01_00_00, 0, 8'b0, 4);
        add_row(4'b1100, 8'b01_01_00_00, 8'b0, {6'd2, 6'd2, 6'd0, 6'd0},
                8'b0, 2, 8'b00_00_11_10, 12);
        add_row(4'b0110, 8'b00_00_00_00, 8'b00_11_01_00, {6'd0, 6'd5, 6'd5, 6'd0},
                8'b0, 2, 8'b00_00_01_10, 16);      // prio beats the pointer
        for (int n = 0; n < 3; n++) begin
            add_row(4'b1111, 8'b11_11_11_11, 8'b10_10_10_10, {4{6'd3}},
                    8'b0, 4, 8'b10_01_00_11, 28);  // pointer left at 3
        end
        add_row(4'b0011, 8'b00_00_10_10, 8'b0, {6'd0, 6'd0, 6'd30, 6'd30}, 8'b0, 0, 8'b0, 0);
        add_row(4'b0011, 8'b00_00_10_10, 8'b0, {6'd0, 6'd0, 6'd30, 6'd30}, 8'b0, 0, 8'b0, 0);
        add_row(4'b0001, 8'b00_00_00_10, 8'b0, {6'd0, 6'd0, 6'd0, 6'd1}, 8'b0, 0, 8'b0, 8);

        limit = 0;
        for (int r = 0; r < n_rows; r++) begin
            for (int p = 0; p < NP; p++) limit += words_of(r, p);
        end
        limit = limit * 4 + 200;

        repeat (3) @(posedge clk);
        #5;
        arst_n = 1'b1;
        check_idle();
        for (int r = 0; r < n_rows; r++) send_row(r);
        while (!drained()) begin
            @(posedge clk);
            #5;
        end
        repeat (4) @(posedge clk);
        #5;
        check_bit("full", full, 1'b0);
        check_bit("full seen during the fill rows", full_seen, 1'b1);

        $display("errors: %0d value mismatches, %0d other", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pkt_switch.f
src/pkt_switch_pkg.sv
src/packet_fifo.sv
src/ingress_port.sv
src/egress_port.sv
src/pkt_switch.sv
verification/pkt_switch_tb.sv
